//--- all.f
rtl/boardPkg.sv
rtl/ioMapPkg.sv
rtl/boardBusIf.sv
rtl/devBoard.sv
rtl/busSequencer.sv
rtl/intController.sv
rtl/boardTop.sv
tb/busSeq_properties.sv
tb/boardTb.sv

//--- Makefile
# Verilator build and run for the board I/O testbench

BIN := obj_dir/VboardTb
SRCS := $(shell cat all.f)

.PHONY: all run check clean

all: $(BIN)

$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module boardTb -f all.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -qxF 'PASS: all tests' sim.log

check:
	grep -qxF 'PASS: all tests' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/boardTb.sv
// testbench with clock and reset, pin memory model, directed tests, compare tasks and summary
`timescale 1ns/10ps

module boardTb;

	logic CLK;
	logic RESET;
	logic reqValid;
	logic reqWrite;
	logic [boardPkg::ADDR_W-1:0] reqAddr;
	boardPkg::busWord_u reqData;
	boardPkg::byteEn_t reqByteEn;
	logic busy;
	logic respValid;
	boardPkg::busWord_u respData;
	logic [boardPkg::ADDR_W-1:0] pinAddr;
	wire [boardPkg::DATA_W-1:0] pinDbus;
	logic pinRdn;
	logic pinWr0n;
	logic pinWr1n;
	logic [7:0] pinLed;
	logic [3:0] pinDipsw;
	logic [ioMapPkg::NUM_INTS-1:0] pinInt;
	logic intReq;
	logic [ioMapPkg::INT_ID_W-1:0] intId;
	logic intAck;
	logic [ioMapPkg::INT_ID_W-1:0] intAckId;

	logic [15:0] mem [0:65535]; // external memory on the pins
	logic [7:0] latchLo;
	logic [7:0] latchHi;
	logic loLow; // lane strobe was low at the last falling clock
	logic hiLow;
	int strobeCount = 0;
	string curTest;
	int errorCount = 0;
	int testErrors;
	int testCount = 0;

	boardTop dut0 (
		.CLK(CLK), .RESET(RESET),
		.reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
		.reqData(reqData), .reqByteEn(reqByteEn),
		.busy(busy), .respValid(respValid), .respData(respData),
		.PIN_ADDR(pinAddr), .PIN_DBUS(pinDbus), .PIN_RDN(pinRdn),
		.PIN_WR0N(pinWr0n), .PIN_WR1N(pinWr1n),
		.PIN_LED(pinLed), .PIN_DIPSW(pinDipsw),
		.PIN_INT(pinInt), .intReq(intReq), .intId(intId),
		.intAck(intAck), .intAckId(intAckId)
	);

	always #20 CLK = ~CLK;

	assign pinDbus = !pinRdn ? mem[pinAddr] : 'z; // memory answers reads

	// lane data and strobe state, taken mid-cycle
	always @(negedge CLK) begin
		loLow <= !pinWr0n;
		hiLow <= !pinWr1n;
		latchLo <= pinDbus[7:0];
		latchHi <= pinDbus[15:8];
		if (!pinRdn || !pinWr0n || !pinWr1n) begin
			strobeCount <= strobeCount + 1;
		end
	end

	always @(posedge pinWr0n or posedge pinWr1n) begin
		if (loLow && pinWr0n) begin
			mem[pinAddr][7:0] <= latchLo;
		end
		if (hiLow && pinWr1n) begin
			mem[pinAddr][15:8] <= latchHi;
		end
	end

	task automatic checkWord(input boardPkg::busWord_u exp, input boardPkg::busWord_u act);
		if (exp.word !== act.word) begin
			$display("mismatch in %s: expected %h_%h, actual %h_%h", curTest,
				exp.bytes.hi, exp.bytes.lo, act.bytes.hi, act.bytes.lo);
			errorCount++;
		end
	endtask

	task automatic checkLed(input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("mismatch in %s: expected LED %h, actual %h", curTest, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkInt(input logic [ioMapPkg::INT_ID_W-1:0] exp,
		input logic [ioMapPkg::INT_ID_W-1:0] act);
		if (exp !== act) begin
			$display("mismatch in %s: expected intId %0d, actual %0d", curTest, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch in %s: expected %s %b, actual %b", curTest, what, exp, act);
			errorCount++;
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("test %s finished with %0d errors", curTest, errorCount - testErrors);
	endtask

	// one host access, waits for respValid
	task automatic hostAccess(input logic write, input logic [15:0] addr,
		input boardPkg::busWord_u data, input boardPkg::byteEn_t be,
		output boardPkg::busWord_u rd);
		int waited;
		@(posedge CLK);
		#2;
		reqValid = 1'b1;
		reqWrite = write;
		reqAddr = addr;
		reqData = data;
		reqByteEn = be;
		@(posedge CLK);
		#2;
		reqValid = 1'b0;
		waited = 0;
		while (!respValid && waited < 20) begin
			@(posedge CLK);
			#2;
			waited++;
		end
		if (!respValid) begin
			$display("timeout in %s: no respValid within 20 cycles", curTest);
			errorCount++;
			rd = '0;
		end else begin
			rd = respData;
		end
	endtask

	task automatic waitIntReq();
		int waited;
		waited = 0;
		while (!intReq && waited < 20) begin
			@(posedge CLK);
			#2;
			waited++;
		end
		if (!intReq) begin
			$display("timeout in %s: intReq never went high", curTest);
			errorCount++;
		end
	endtask

	// ack clears next cycle, intId follows one cycle later
	task automatic ackLine(input logic [ioMapPkg::INT_ID_W-1:0] id);
		intAck = 1'b1;
		intAckId = id;
		@(posedge CLK);
		#2;
		intAck = 1'b0;
		@(posedge CLK);
		#2;
	endtask

	task automatic testWordRw();
		boardPkg::busWord_u wd;
		boardPkg::busWord_u rd;
		logic [15:0] addr;
		startTest("word write/read");
		for (int i = 0; i < 8; i++) begin
			addr = 16'($urandom_range(32'(ioMapPkg::GPIO_BASE) - 1));
			wd.word = 16'($urandom);
			hostAccess(1'b1, addr, wd, 2'b11, rd);
			checkWord(16'h0000, rd); // writes answer zero
			hostAccess(1'b0, addr, '0, 2'b11, rd);
			checkWord(wd, rd);
			checkWord(wd, mem[addr]);
		end
		endTest();
	endtask

	task automatic testByteLanes();
		boardPkg::busWord_u prev;
		boardPkg::busWord_u wd;
		boardPkg::busWord_u exp;
		boardPkg::busWord_u rd;
		logic [15:0] addr;
		startTest("byte lanes");
		addr = 16'($urandom_range(32'(ioMapPkg::GPIO_BASE) - 1));
		prev.word = 16'($urandom);
		hostAccess(1'b1, addr, prev, 2'b11, rd);
		for (int lane = 0; lane < 2; lane++) begin
			wd.word = ~prev.word; // every bit differs
			exp = prev;
			if (lane == 0) begin
				exp.bytes.lo = wd.bytes.lo;
			end else begin
				exp.bytes.hi = wd.bytes.hi;
			end
			hostAccess(1'b1, addr, wd, (lane == 0) ? 2'b01 : 2'b10, rd);
			hostAccess(1'b0, addr, '0, 2'b11, rd);
			checkWord(exp, rd);
			prev = exp;
		end
		endTest();
	endtask

	task automatic testGpio();
		boardPkg::busWord_u wd;
		boardPkg::busWord_u rd;
		logic [7:0] led;
		logic [3:0] dip;
		int strobesBefore;
		startTest("GPIO");
		strobesBefore = strobeCount;
		led = 8'($urandom) | 8'h01;
		wd.word = {8'hA5, led}; // high byte must not matter
		hostAccess(1'b1, {ioMapPkg::GPIO_BASE[15:8], ioMapPkg::GPIO_LED_OFFSET}, wd, 2'b01, rd);
		checkLed(led, pinLed);
		hostAccess(1'b0, {ioMapPkg::GPIO_BASE[15:8], ioMapPkg::GPIO_LED_OFFSET}, '0, 2'b11, rd);
		checkWord({8'h00, led}, rd);
		dip = 4'($urandom) | 4'h8;
		pinDipsw = dip;
		hostAccess(1'b0, {ioMapPkg::GPIO_BASE[15:8], ioMapPkg::GPIO_DIP_OFFSET}, '0, 2'b11, rd);
		checkWord({12'h000, dip}, rd);
		if (strobeCount != strobesBefore) begin
			$display("error in %s: a pin strobe went low during a GPIO access", curTest);
			errorCount++;
		end
		endTest();
	endtask

	task automatic testBusyDrop();
		boardPkg::busWord_u dA;
		boardPkg::busWord_u oldB;
		logic [15:0] addrA;
		logic [15:0] addrB;
		int respCount;
		startTest("busy drop");
		addrA = 16'($urandom_range(32'h7FFF));
		addrB = addrA + 16'h4000;
		oldB.word = mem[addrB];
		dA.word = 16'($urandom);
		@(posedge CLK);
		#2;
		reqValid = 1'b1;
		reqWrite = 1'b1;
		reqAddr = addrA;
		reqData = dA;
		reqByteEn = 2'b11;
		@(posedge CLK);
		#2;
		checkFlag("busy", 1'b1, busy); // first request taken at the last edge
		reqAddr = addrB; // second strobe while busy
		reqData = ~dA.word;
		@(posedge CLK);
		#2;
		reqValid = 1'b0;
		respCount = 0;
		for (int n = 0; n < 12; n++) begin
			checkFlag("busy", respCount == 0, busy); // high through the response cycle
			if (respValid) begin
				respCount++;
			end
			@(posedge CLK);
			#2;
		end
		if (respCount != 1) begin
			$display("mismatch in %s: expected 1 response, actual %0d", curTest, respCount);
			errorCount++;
		end
		checkWord(dA, mem[addrA]);
		checkWord(oldB, mem[addrB]);
		endTest();
	endtask

	task automatic testInterrupts();
		startTest("interrupts");
		@(posedge CLK);
		#2;
		pinInt[5] = 1'b1;
		pinInt[2] = 1'b1;
		waitIntReq();
		checkInt(3'd2, intId);
		ackLine(3'd2);
		checkFlag("intReq", 1'b1, intReq);
		checkInt(3'd5, intId);
		ackLine(3'd5);
		checkFlag("intReq", 1'b0, intReq);
		pinInt = '0;
		endTest();
	endtask

	task automatic testResetState();
		boardPkg::busWord_u rd;
		logic [15:0] addr;
		startTest("reset state");
		hostAccess(1'b1, {ioMapPkg::GPIO_BASE[15:8], ioMapPkg::GPIO_LED_OFFSET},
			16'h00C3, 2'b01, rd);
		pinInt[6] = 1'b1;
		waitIntReq();
		// external read, RESET lands while its strobe is low
		addr = 16'($urandom_range(32'(ioMapPkg::GPIO_BASE) - 1));
		@(posedge CLK);
		#2;
		reqValid = 1'b1;
		reqWrite = 1'b0;
		reqAddr = addr;
		reqData = '0;
		reqByteEn = 2'b11;
		@(posedge CLK);
		#2;
		reqValid = 1'b0;
		@(posedge CLK);
		#2;
		checkFlag("PIN_RDN", 1'b0, pinRdn); // first strobe cycle
		RESET = 1'b1;
		pinInt = '0; // no new edge once reset drops
		#1;
		checkFlag("PIN_RDN", 1'b1, pinRdn);
		repeat (2) @(posedge CLK);
		#2;
		RESET = 1'b0;
		@(posedge CLK);
		#2;
		checkLed(8'h00, pinLed);
		checkFlag("PIN_RDN", 1'b1, pinRdn);
		checkFlag("PIN_WR0N", 1'b1, pinWr0n);
		checkFlag("PIN_WR1N", 1'b1, pinWr1n);
		checkFlag("busy", 1'b0, busy);
		checkFlag("intReq", 1'b0, intReq);
		endTest();
	endtask

	initial begin
		void'($urandom(28));
		CLK = 1'b0;
		RESET = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqData = '0;
		reqByteEn = 2'b00;
		pinDipsw = 4'h0;
		pinInt = '0;
		intAck = 1'b0;
		intAckId = '0;
		for (int a = 0; a < 65536; a++) begin
			mem[a] = {a[7:0], a[15:8]} ^ 16'h5AC3;
		end
		repeat (8) @(posedge CLK);
		#2;
		RESET = 1'b0;
		testWordRw();
		testByteLanes();
		testGpio();
		testBusyDrop();
		testInterrupts();
		testResetState();
		$display("summary: %0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tb/busSeq_properties.sv
// concurrent assertions on sequencer strobes and response timing bound to busSequencer
`timescale 1ns/10ps

module busSeqProperties (
	input logic CLK,
	input logic RESET,
	input logic reqValid,
	input logic busy,
	input logic respValid,
	input boardPkg::byteEn_t byteEn,
	input logic rdn,
	input logic wr0n,
	input logic wr1n
);

	logic accepted;
	boardPkg::byteEn_t acceptedBe; // host byte enable of the access in flight

	assign accepted = reqValid && !busy; // same rule the host sees

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			acceptedBe <= '0;
		end else if (accepted) begin
			acceptedBe <= byteEn;
		end
	end

	// both lanes low only on a full word write
	singleLane: assert property (@(posedge CLK) disable iff (RESET)
		(!wr0n && !wr1n) |-> (acceptedBe == 2'b11))
		else $error("both write strobes low with byte enable %b", acceptedBe);

	respTiming: assert property (@(posedge CLK) disable iff (RESET)
		accepted |-> ##(boardPkg::ACCESS_CYCLES) respValid)
		else $error("respValid missing after an accepted request");

	// no response without a request at the right distance
	noStrayResp: assert property (@(posedge CLK) disable iff (RESET)
		respValid |-> $past(accepted, boardPkg::ACCESS_CYCLES))
		else $error("respValid without a request ACCESS_CYCLES earlier");

	quietInReset: assert property (@(posedge CLK)
		RESET |-> (rdn && wr0n && wr1n))
		else $error("bus strobe low during reset");

endmodule

bind busSequencer busSeqProperties props0 (
	.CLK(CLK),
	.RESET(RESET),
	.reqValid(reqValid),
	.busy(busy),
	.respValid(respValid),
	.byteEn(reqByteEn),
	.rdn(bus.rdn),
	.wr0n(bus.wr0n),
	.wr1n(bus.wr1n)
);

//--- rtl/boardTop.sv
// board top level: sequencer, pin layer and interrupt controller on plain ports
`timescale 1ns/10ps

module boardTop (
	input logic CLK,
	input logic RESET,
	input logic reqValid,
	input logic reqWrite,
	input logic [boardPkg::ADDR_W-1:0] reqAddr,
	input boardPkg::busWord_u reqData,
	input boardPkg::byteEn_t reqByteEn,
	output logic busy,
	output logic respValid,
	output boardPkg::busWord_u respData,
	output logic [boardPkg::ADDR_W-1:0] PIN_ADDR,
	inout wire [boardPkg::DATA_W-1:0] PIN_DBUS,
	output logic PIN_RDN,
	output logic PIN_WR0N,
	output logic PIN_WR1N,
	output logic [7:0] PIN_LED,
	input logic [3:0] PIN_DIPSW,
	input logic [ioMapPkg::NUM_INTS-1:0] PIN_INT,
	output logic intReq,
	output logic [ioMapPkg::INT_ID_W-1:0] intId,
	input logic intAck,
	input logic [ioMapPkg::INT_ID_W-1:0] intAckId
);

	boardBusIf bus0 ();

	busSequencer seq0 (
		.CLK(CLK),
		.RESET(RESET),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqByteEn(reqByteEn),
		.busy(busy),
		.respValid(respValid),
		.respData(respData),
		.bus(bus0.seq)
	);

	devBoard board0 (
		.CLK(CLK),
		.RESET(RESET),
		.bus(bus0.board),
		.PIN_ADDR(PIN_ADDR),
		.PIN_DBUS(PIN_DBUS),
		.PIN_RDN(PIN_RDN),
		.PIN_WR0N(PIN_WR0N),
		.PIN_WR1N(PIN_WR1N),
		.PIN_LED(PIN_LED),
		.PIN_DIPSW(PIN_DIPSW)
	);

	intController int0 (
		.CLK(CLK),
		.RESET(RESET),
		.PIN_INT(PIN_INT),
		.intReq(intReq),
		.intId(intId),
		.intAck(intAck),
		.intAckId(intAckId)
	);

endmodule

//--- rtl/intController.sv
// interrupt controller: pin synchronizers, rising edge detect, pending bits, lowest-first encoder
`timescale 1ns/10ps

module intController (
	input logic CLK,
	input logic RESET,
	input logic [ioMapPkg::NUM_INTS-1:0] PIN_INT,
	output logic intReq,
	output logic [ioMapPkg::INT_ID_W-1:0] intId,
	input logic intAck,
	input logic [ioMapPkg::INT_ID_W-1:0] intAckId
);

	logic [ioMapPkg::NUM_INTS-1:0] sync1;
	logic [ioMapPkg::NUM_INTS-1:0] sync2;
	logic [ioMapPkg::NUM_INTS-1:0] prevLevel; // edge register
	logic [ioMapPkg::NUM_INTS-1:0] rise;
	logic [ioMapPkg::NUM_INTS-1:0] ackMask;
	logic [ioMapPkg::NUM_INTS-1:0] pending;
	logic [ioMapPkg::NUM_INTS-1:0] pendingNext;
	logic [ioMapPkg::INT_ID_W-1:0] lowestId;

	assign rise = sync2 & ~prevLevel;

	// one-hot clear for the acknowledged line
	always_comb begin
		ackMask = '0;
		if (intAck && (int'(intAckId) < ioMapPkg::NUM_INTS)) begin
			ackMask[intAckId] = 1'b1;
		end
	end

	// fresh edge beats an ack on the same line
	assign pendingNext = (pending & ~ackMask) | rise;

	// scan downward so the lowest pending line ends up in lowestId
	always_comb begin
		lowestId = '0;
		for (int i = ioMapPkg::NUM_INTS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				lowestId = i[ioMapPkg::INT_ID_W-1:0];
			end
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			sync1 <= '0;
			sync2 <= '0;
			prevLevel <= '0;
			pending <= '0;
			intReq <= 1'b0;
			intId <= '0;
		end else begin
			sync1 <= PIN_INT;
			sync2 <= sync1;
			prevLevel <= sync2;
			pending <= pendingNext;
			intReq <= |pending;
			intId <= lowestId;
		end
	end

endmodule

//--- rtl/busSequencer.sv
// bus sequencer: host request latch, phase counter, address decode, strobes, read capture
`timescale 1ns/10ps

module busSequencer (
	input logic CLK,
	input logic RESET,
	input logic reqValid,
	input logic reqWrite,
	input logic [boardPkg::ADDR_W-1:0] reqAddr,
	input boardPkg::busWord_u reqData,
	input boardPkg::byteEn_t reqByteEn,
	output logic busy,
	output logic respValid,
	output boardPkg::busWord_u respData,
	boardBusIf.seq bus
);

	logic [boardPkg::PHASE_W-1:0] phase; // 0 idle, then setup, strobes, release
	logic accept;
	logic [boardPkg::ADDR_W-1:0] addrReg;
	logic writeReg;
	boardPkg::busWord_u dataReg;
	boardPkg::byteEn_t byteEnReg;
	boardPkg::busWord_u rdData;
	logic isGpio;
	logic strobePhase;
	logic rdCycle;
	logic wrCycle;

	assign busy = (phase != '0);
	assign accept = reqValid && !busy; // requests while busy are dropped

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= '0;
			addrReg <= '0; // keeps PIN_ADDR at zero until the first access
		end else if (accept) begin
			phase <= boardPkg::PHASE_SETUP;
			addrReg <= reqAddr;
		end else if (busy) begin
			if (phase == boardPkg::PHASE_RELEASE) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// request payload
	always_ff @(posedge CLK) begin
		if (accept) begin
			writeReg <= reqWrite;
			dataReg <= reqData;
			byteEnReg <= reqByteEn;
		end
	end

	// upper byte match against the GPIO window
	assign isGpio = (addrReg[boardPkg::ADDR_W-1:boardPkg::ADDR_W-8]
		== ioMapPkg::GPIO_BASE[15:8]);

	assign strobePhase = (phase >= boardPkg::PHASE_STROBE_FIRST)
		&& (phase <= boardPkg::PHASE_STROBE_LAST);
	assign rdCycle = strobePhase && !writeReg;
	assign wrCycle = strobePhase && writeReg;

	assign bus.addr = addrReg;
	assign bus.dout = dataReg;

	// external strobes, only enabled lanes on a write
	assign bus.rdn = !(rdCycle && !isGpio);
	assign bus.wr0n = !(wrCycle && byteEnReg[0] && !isGpio);
	assign bus.wr1n = !(wrCycle && byteEnReg[1] && !isGpio);

	// GPIO side, LED write goes through the low lane
	assign bus.rdGpio = rdCycle && isGpio;
	assign bus.wrGpio = wrCycle && byteEnReg[0] && isGpio;
	assign bus.addrGpio = (addrReg[7:0] == ioMapPkg::GPIO_LED_OFFSET);

	// read data sampled at the end of the last strobe cycle
	always_ff @(posedge CLK) begin
		if (accept) begin
			rdData <= '0; // writes answer with zero
		end else if (rdCycle && (phase == boardPkg::PHASE_STROBE_LAST)) begin
			if (isGpio) begin
				rdData.bytes.hi <= '0;
				rdData.bytes.lo <= bus.dinGpio;
			end else begin
				rdData <= bus.din;
			end
		end
	end

	assign respValid = (phase == boardPkg::PHASE_RELEASE);
	assign respData = rdData;

endmodule

//--- rtl/devBoard.sv
// pin layer: data bus tristate, reset-safe strobes, DIP and LED registers, GPIO read mux
`timescale 1ns/10ps

module devBoard (
	input logic CLK,
	input logic RESET,
	boardBusIf.board bus,
	output logic [boardPkg::ADDR_W-1:0] PIN_ADDR,
	inout wire [boardPkg::DATA_W-1:0] PIN_DBUS,
	output logic PIN_RDN,
	output logic PIN_WR0N,
	output logic PIN_WR1N,
	output logic [7:0] PIN_LED,
	input logic [3:0] PIN_DIPSW
);

	logic [3:0] dipReg; // DIP switches, one cycle behind the pins
	logic driveBus;

	// address and strobes go straight out, held idle while in reset
	always_comb begin
		if (RESET) begin
			PIN_ADDR = '0;
			PIN_RDN = 1'b1;
			PIN_WR0N = 1'b1;
			PIN_WR1N = 1'b1;
		end else begin
			PIN_ADDR = bus.addr;
			PIN_RDN = bus.rdn;
			PIN_WR0N = bus.wr0n;
			PIN_WR1N = bus.wr1n;
		end
	end

	// only drive the data pins while a write strobe is low
	assign driveBus = !PIN_WR0N || !PIN_WR1N;
	assign PIN_DBUS = driveBus ? bus.dout.word : 'z;

	// pins during a read, own write data otherwise
	always_comb begin
		if (!bus.rdn) begin
			bus.din = PIN_DBUS;
		end else begin
			bus.din = bus.dout.word;
		end
	end

	// GPIO read data
	always_comb begin
		if (bus.rdGpio && !bus.addrGpio) begin
			bus.dinGpio = {4'h0, dipReg}; // zero above the switches
		end else begin
			bus.dinGpio = PIN_LED; // LED readback
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			dipReg <= '0;
		end else begin
			dipReg <= PIN_DIPSW;
		end
	end

	// LED register takes the low byte
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			PIN_LED <= '0;
		end else if (bus.wrGpio && bus.addrGpio) begin
			PIN_LED <= bus.dout.bytes.lo;
		end
	end

endmodule

//--- rtl/boardBusIf.sv
// internal bus between sequencer and pin layer, with seq and board modports
`timescale 1ns/10ps

interface boardBusIf;

	logic [boardPkg::ADDR_W-1:0] addr;
	boardPkg::busWord_u dout; // write data
	boardPkg::busWord_u din; // read data back from the pins
	logic rdn;
	logic wr0n; // low lane strobe
	logic wr1n; // high lane strobe
	logic rdGpio;
	logic wrGpio;
	logic addrGpio; // 1 selects the LED register
	logic [7:0] dinGpio;

	modport seq (
		output addr, dout, rdn, wr0n, wr1n, rdGpio, wrGpio, addrGpio,
		input din, dinGpio
	);

	modport board (
		input addr, dout, rdn, wr0n, wr1n, rdGpio, wrGpio, addrGpio,
		output din, dinGpio
	);

endinterface

//--- rtl/ioMapPkg.sv
// GPIO address map and interrupt line constants
package ioMapPkg;

	// upper address byte selects the GPIO block
	localparam logic [15:0] GPIO_BASE = 16'hFF00;

	localparam logic [7:0] GPIO_DIP_OFFSET = 8'h00; // DIP switches, low nibble
	localparam logic [7:0] GPIO_LED_OFFSET = 8'h01; // LED register

	localparam int NUM_INTS = 7;
	localparam int INT_ID_W = 3; // enough for NUM_INTS

endpackage

//--- rtl/boardPkg.sv
// bus word union, byte enable type, bus widths and access phase timing
package boardPkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// one data word, taken whole or per byte lane
	typedef union packed {
		logic [DATA_W-1:0] word;
		struct packed {
			logic [DATA_W/2-1:0] hi; // WR1N lane
			logic [DATA_W/2-1:0] lo; // WR0N lane
		} bytes;
	} busWord_u;

	typedef logic [1:0] byteEn_t; // bit 0 low lane, bit 1 high lane

	localparam int STROBE_CYCLES = 2; // strobe low time
	localparam int ACCESS_CYCLES = 4; // setup, strobes, release

	// phase counter values, 0 is idle
	localparam int PHASE_W = $clog2(ACCESS_CYCLES + 1);
	localparam logic [PHASE_W-1:0] PHASE_SETUP = PHASE_W'(1);
	localparam logic [PHASE_W-1:0] PHASE_STROBE_FIRST = PHASE_W'(2);
	localparam logic [PHASE_W-1:0] PHASE_STROBE_LAST = PHASE_W'(1 + STROBE_CYCLES);
	localparam logic [PHASE_W-1:0] PHASE_RELEASE = PHASE_W'(ACCESS_CYCLES);

endpackage
